// ==== hdl/video_pkg.sv ====
// shared types and bus address map of the tile video path
// every module refers to these with video_pkg:: scoped names
// compile this file before any module that uses it

package video_pkg;

    // --------------------------------------------------
    // beam position and sync for one pixel
    // --------------------------------------------------
    typedef struct packed {
        logic [8:0] hdump;  // horizontal position, 0 to H_TOTAL-1
        logic [8:0] vdump;  // line number, 0 to V_TOTAL-1
        logic       lhbl;   // low while in horizontal blanking
        logic       lvbl;   // low while in vertical blanking
        logic       hs;     // horizontal sync, active high
        logic       vs;     // vertical sync, active high
    } timing_t;

    // what the tile stage hands on next to the colour index
    typedef struct packed {
        timing_t timing;    // position the index belongs to
        logic    sel;       // 1 picks the high nibble of the tile entry
    } fetch_ctl_t;

    // one write from the CPU into a video memory
    // strobes last a single clock
    typedef struct packed {
        logic        tile_we;   // write into the tile map
        logic        pal_we;    // write into the palette
        logic [9:0]  addr;      // word offset inside the target memory
        logic [11:0] data;      // tile map keeps 7:0, palette keeps 11:0
    } bus_write_t;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // --------------------------------------------------
    // word addresses on the 11-bit Wishbone bus
    // --------------------------------------------------
    localparam logic [10:0] TILE_BASE   = 11'h000; // 1024 tile map entries
    localparam logic [10:0] PAL_BASE    = 11'h400; // 16 palette entries
    localparam logic [10:0] STATUS_ADDR = 11'h410; // frame count and line

endpackage

// ==== hdl/video_delay.sv ====
// register chain that carries side data next to a pipeline stage
// advances only on the pixel enable so it stays in step with the pixels
// the payload type is set per instance

`timescale 1ns/1ps

module video_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1        // number of pixel steps of delay
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pxl_cen,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];    // stage 0 takes din, the last one drives dout

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (pxl_cen) begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];     // shift one step per pixel
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// ==== hdl/video_timer.sv ====
// video timer of the tile display
// counts pixels and lines on the pixel enable and derives blanking and sync
// flags are registered from the next count so they line up with hdump/vdump
// frame_cnt counts rising edges of vs for the CPU status word

`timescale 1ns/1ps

module video_timer #(
    parameter int LAYOUT  = 0,      // 3 moves vertical blanking up by one line
    parameter int H_TOTAL = 384,    // pixels per line
    parameter int V_TOTAL = 264     // lines per frame
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    output video_pkg::timing_t timing,
    output logic [15:0]        frame_cnt
);

    // --------------------------------------------------
    // layout, all positions taken from the totals
    // --------------------------------------------------
    localparam int         VB_SHIFT = (LAYOUT == 3) ? 1 : 0;
    localparam logic [8:0] H_LAST   = 9'(H_TOTAL - 1);
    localparam logic [8:0] V_LAST   = 9'(V_TOTAL - 1);
    localparam logic [8:0] HB_START = 9'(H_TOTAL - 128);   // 256, blank to end of line
    localparam logic [8:0] HS_START = 9'(H_TOTAL - 84);    // 300
    localparam logic [8:0] HS_END   = 9'(H_TOTAL - 66);    // 318, last sync pixel
    localparam logic [8:0] VS_START = 9'(V_TOTAL - 4);     // 260
    localparam logic [8:0] VS_END   = 9'(V_TOTAL - 2);     // 262, last sync line
    localparam logic [8:0] VB_START = 9'(V_TOTAL - 25 - VB_SHIFT); // 239 or 238
    localparam logic [8:0] VB_END   = 9'(15 - VB_SHIFT);   // first visible line, 15 or 14

    logic [8:0] h_next;     // position after the coming pixel enable
    logic [8:0] v_next;
    logic       vs_l;       // vs one clock ago, for edge detection

    always_comb begin
        h_next = (timing.hdump == H_LAST) ? 9'd0 : timing.hdump + 9'd1;
        v_next = timing.vdump;
        if (timing.hdump == H_LAST) begin
            v_next = (timing.vdump == V_LAST) ? 9'd0 : timing.vdump + 9'd1; // step at wrap
        end
    end

    // --------------------------------------------------
    // counters and flags
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing.hdump <= 9'd0;
            timing.vdump <= 9'd0;
            timing.lhbl  <= 1'b1;                   // pixel 0 is visible
            timing.lvbl  <= (VB_END == 9'd0);       // line 0 sits inside vblank
            timing.hs    <= 1'b0;
            timing.vs    <= 1'b0;
        end else if (pxl_cen) begin
            timing.hdump <= h_next;
            timing.vdump <= v_next;
            timing.lhbl  <= h_next < HB_START;
            // vertical blanking wraps through line 0
            timing.lvbl  <= !(v_next >= VB_START || v_next < VB_END);
            timing.hs    <= (h_next >= HS_START) && (h_next <= HS_END);
            timing.vs    <= (v_next >= VS_START) && (v_next <= VS_END);
        end
    end

    // frame number, one step per vs rising edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vs_l      <= 1'b0;
            frame_cnt <= 16'd0;
        end else begin
            vs_l <= timing.vs;
            if (timing.vs && !vs_l) begin
                frame_cnt <= frame_cnt + 16'd1;    // wraps after 65535 frames
            end
        end
    end

endmodule

// ==== hdl/tile_fetch.sv ====
// tile stage of the pixel pipeline
// holds the 32x32 tile map written by the CPU and reads one entry per pixel
// each 8x8 tile shows its two colour indices in a 4x4 checkerboard
// outputs the index together with the delayed timing of the same pixel

`timescale 1ns/1ps

module tile_fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  video_pkg::timing_t    timing,
    input  video_pkg::bus_write_t wr,
    output video_pkg::fetch_ctl_t ctl,
    output logic [3:0]            color
);

    // --------------------------------------------------
    // tile map, one byte per tile
    // --------------------------------------------------
    logic [7:0] tile_ram [1024];    // high nibble and low nibble colour indices
    logic [7:0] tile_q;             // entry of the pixel now in ctl
    logic [9:0] tile_addr;          // row in 9:5, column in 4:0
    video_pkg::fetch_ctl_t ctl_d;   // control of the pixel being fetched

    // only the visible 256x256 area has tiles, higher bits of the count are dropped
    assign tile_addr = {timing.vdump[7:3], timing.hdump[7:3]};

    always_comb begin
        ctl_d.timing = timing;
        // checkerboard of 4x4 cells inside every tile
        ctl_d.sel    = timing.hdump[2] ^ timing.vdump[2];
    end

    // CPU write port, the strobe lasts one clock
    always_ff @(posedge clk) begin
        if (wr.tile_we) begin
            tile_ram[wr.addr] <= wr.data[7:0];
        end
    end

    // read port, one entry per pixel step
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            tile_q <= tile_ram[tile_addr];
        end
    end

    // --------------------------------------------------
    // side data, one step so it meets tile_q
    // --------------------------------------------------
    video_delay #(
        .payload_t (video_pkg::fetch_ctl_t),
        .DEPTH     (1)
    ) ctl_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .din     (ctl_d),
        .dout    (ctl)
    );

    // pick the nibble from the registered entry
    assign color = ctl.sel ? tile_q[7:4] : tile_q[3:0];

endmodule

// ==== hdl/palette_lookup.sv ====
// palette stage, last step of the pixel pipeline
// turns the 4-bit colour index into 12-bit RGB from a CPU written palette
// the colour is forced to black whenever either blanking flag is low

`timescale 1ns/1ps

module palette_lookup (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  video_pkg::fetch_ctl_t ctl,
    input  logic [3:0]            color,
    input  video_pkg::bus_write_t wr,
    output video_pkg::timing_t    timing,
    output video_pkg::rgb_t       rgb
);

    logic [11:0] pal_ram [16];  // r in 11:8, g in 7:4, b in 3:0
    logic        blank;         // pixel lies in horizontal or vertical blanking

    assign blank = !ctl.timing.lhbl || !ctl.timing.lvbl;

    // --------------------------------------------------
    // palette write port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr.pal_we) begin
            pal_ram[wr.addr[3:0]] <= wr.data;   // upper address bits are decoded by the bus slave
        end
    end

    // lookup, registered once per pixel step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                rgb <= '0;                      // black outside the active area
            end else begin
                rgb <= video_pkg::rgb_t'(pal_ram[color]);
            end
        end
    end

    // timing follows the colour by the same single step
    video_delay #(
        .payload_t (video_pkg::timing_t),
        .DEPTH     (1)
    ) timing_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .din     (ctl.timing),
        .dout    (timing)
    );

endmodule

// ==== hdl/wb_video_regs.sv ====
// Wishbone classic slave for the CPU side of the video
// decodes the tile map, palette and status addresses
// writes leave as one-clock strobes on the clock where ack rises
// reads of the memories return zero, the status word holds frame count and line

`timescale 1ns/1ps

module wb_video_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [10:0]           wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic [31:0]           wb_dat_r,
    input  logic                  wb_we,
    input  logic                  wb_stb,
    input  logic                  wb_cyc,
    output logic                  wb_ack,
    input  logic [15:0]           frame_cnt,
    input  logic [8:0]            vdump,
    output video_pkg::bus_write_t wr
);

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    logic req;          // new access, not yet acknowledged
    logic tile_hit;     // 0x000 to 0x3ff
    logic pal_hit;      // 0x400 to 0x40f
    logic status_hit;   // the single status word

    assign req        = wb_cyc && wb_stb && !wb_ack;   // ack in flight blocks a repeat
    assign tile_hit   = wb_adr[10] == video_pkg::TILE_BASE[10];
    assign pal_hit    = wb_adr[10:4] == video_pkg::PAL_BASE[10:4];
    assign status_hit = wb_adr == video_pkg::STATUS_ADDR;

    // write strobes are high only in the cycle before ack
    // so the memory takes the data on the same edge that raises ack
    always_comb begin
        wr.tile_we = req && wb_we && tile_hit;
        wr.pal_we  = req && wb_we && pal_hit;
        wr.addr    = wb_adr[9:0];
        wr.data    = wb_dat_w[11:0];
    end

    // --------------------------------------------------
    // acknowledge and read data
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;      // one clock per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_dat_r <= 32'd0;
        end else if (req) begin
            if (!wb_we && status_hit) begin
                wb_dat_r <= {7'd0, vdump, frame_cnt};
            end else begin
                wb_dat_r <= 32'd0;      // memories have no read path
            end
        end
    end

endmodule

// ==== hdl/video_top.sv ====
// top level of the tile video path
// timer, tile stage and palette stage in a pipeline, plus the CPU bus slave
// rgb and the timing outputs are aligned to the same pixel

`timescale 1ns/1ps

module video_top #(
    parameter int LAYOUT  = 0,
    parameter int H_TOTAL = 384,
    parameter int V_TOTAL = 264
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pxl_cen,
    input  logic [10:0]     wb_adr,
    input  logic [31:0]     wb_dat_w,
    output logic [31:0]     wb_dat_r,
    input  logic            wb_we,
    input  logic            wb_stb,
    input  logic            wb_cyc,
    output logic            wb_ack,
    output logic [8:0]      hdump,
    output logic [8:0]      vdump,
    output logic            lhbl,
    output logic            lvbl,
    output logic            hs,
    output logic            vs,
    output video_pkg::rgb_t rgb
);

    // --------------------------------------------------
    // pipeline wiring
    // --------------------------------------------------
    video_pkg::timing_t    timer_timing;    // position made by the timer
    video_pkg::fetch_ctl_t fetch_ctl;       // one step later
    video_pkg::timing_t    out_timing;      // two steps later, next to rgb
    video_pkg::bus_write_t bus_wr;
    logic [15:0]           frame_cnt;
    logic [3:0]            color;

    video_timer #(
        .LAYOUT  (LAYOUT),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) video_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .timing    (timer_timing),
        .frame_cnt (frame_cnt)
    );

    tile_fetch tile_fetch_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .timing  (timer_timing),
        .wr      (bus_wr),
        .ctl     (fetch_ctl),
        .color   (color)
    );

    palette_lookup palette_lookup_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .ctl     (fetch_ctl),
        .color   (color),
        .wr      (bus_wr),
        .timing  (out_timing),
        .rgb     (rgb)
    );

    // status shows the timer line, not the delayed one
    wb_video_regs wb_video_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_we     (wb_we),
        .wb_stb    (wb_stb),
        .wb_cyc    (wb_cyc),
        .wb_ack    (wb_ack),
        .frame_cnt (frame_cnt),
        .vdump     (timer_timing.vdump),
        .wr        (bus_wr)
    );

    // split the aligned timing onto the output pins
    assign hdump = out_timing.hdump;
    assign vdump = out_timing.vdump;
    assign lhbl  = out_timing.lhbl;
    assign lvbl  = out_timing.lvbl;
    assign hs    = out_timing.hs;
    assign vs    = out_timing.vs;

endmodule

// ==== bench/video_tb.sv ====
// testbench of the tile video path
// fills the tile map and palette over Wishbone, then follows the beam for three frames
// every output pixel is checked against a reference model built from shadow copies
// run through run_sim.sh with project.f

`timescale 1ns/1ps

module video_tb;

    // --------------------------------------------------
    // display layout of the default configuration
    // --------------------------------------------------
    localparam int          H_TOTAL  = 384;
    localparam int          V_TOTAL  = 264;
    localparam logic [8:0]  H_LAST   = 9'd383;
    localparam logic [8:0]  V_LAST   = 9'd263;
    localparam logic [8:0]  HB_START = 9'd256;
    localparam logic [8:0]  VB_START = 9'd239;
    localparam logic [8:0]  VB_END   = 9'd15;
    localparam int          FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;  // pxl_cen on every other clock
    localparam int          BUS_CYCLES   = 4 * (1024 + 2 * 16 + 8);
    localparam int          TIMEOUT_CYCLES = 3 * FRAME_CYCLES + FRAME_CYCLES / 2 + BUS_CYCLES;
    localparam int          ACK_LIMIT = 16;
    localparam logic [31:0] LFSR_SEED = 32'h71dfe6e6;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            pxl_cen;
    logic [10:0]     wb_adr;
    logic [31:0]     wb_dat_w;
    logic [31:0]     wb_dat_r;
    logic            wb_we;
    logic            wb_stb;
    logic            wb_cyc;
    logic            wb_ack;
    logic [8:0]      hdump;
    logic [8:0]      vdump;
    logic            lhbl;
    logic            lvbl;
    logic            hs;
    logic            vs;
    video_pkg::rgb_t rgb;
    logic [11:0]     rgb_word;          // rgb as one 12-bit value

    logic [7:0]  tile_shadow [1024];    // what the CPU wrote into the tile map
    logic [11:0] pal_shadow [16];
    logic [31:0] lfsr_state = LFSR_SEED;
    logic        pix_check = 1'b0;      // pixel values are compared only while set
    int          out_steps = 0;         // output pixels seen since reset
    int          cycle_count = 0;
    logic [8:0]  prev_h;
    logic [8:0]  prev_v;

    assign rgb_word = rgb;

    video_top #(
        .LAYOUT  (0),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) video_top_inst (
        .clk (clk), .rst_n (rst_n), .pxl_cen (pxl_cen),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r),
        .wb_we (wb_we), .wb_stb (wb_stb), .wb_cyc (wb_cyc), .wb_ack (wb_ack),
        .hdump (hdump), .vdump (vdump), .lhbl (lhbl), .lvbl (lvbl),
        .hs (hs), .vs (vs), .rgb (rgb)
    );

    always #4 clk = ~clk;   // 8 ns period

    // pixel enable on every other clock, 1 ns after the edge
    always @(posedge clk) begin
        #1;
        pxl_cen = ~pxl_cen;
    end

    // --------------------------------------------------
    // error reporting and random numbers
    // --------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_failure($sformatf("FAILED at time %0t: %s expected %0h, got %0h",
                                    $time, name, expected, actual));
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // returns {lhbl, lvbl, hs, vs} for a beam position
    function automatic logic [3:0] expected_flags(input logic [8:0] h, input logic [8:0] v);
        logic lhbl_e;
        logic lvbl_e;
        logic hs_e;
        logic vs_e;
        lhbl_e = h < HB_START;
        lvbl_e = !(v >= VB_START || v < VB_END);    // vblank wraps through line 0
        hs_e   = h >= 9'd300 && h <= 9'd318;
        vs_e   = v >= 9'd260 && v <= 9'd262;
        return {lhbl_e, lvbl_e, hs_e, vs_e};
    endfunction

    function automatic logic [11:0] expected_rgb(input logic [8:0] h, input logic [8:0] v);
        logic [3:0] flags;
        logic [7:0] entry;
        logic [3:0] index;
        flags = expected_flags(h, v);
        if (!flags[3] || !flags[2]) begin
            return 12'h000;                         // black in either blanking
        end
        entry = tile_shadow[{v[7:3], h[7:3]}];
        index = (h[2] ^ v[2]) ? entry[7:4] : entry[3:0];   // 4x4 checkerboard in a tile
        return pal_shadow[index];
    endfunction

    // --------------------------------------------------
    // bus master
    // --------------------------------------------------
    // starts and ends 1 ns after a rising edge
    // the strobe stays high through the edge where the master samples ack
    task automatic bus_cycle(input logic we, input logic [10:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited   = 0;
        wb_adr   = adr;
        wb_dat_w = wdata;
        wb_we    = we;
        wb_stb   = 1'b1;
        wb_cyc   = 1'b1;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        assert (wb_ack) else stop_with_failure("bus cycle was never acknowledged");
        assert (waited == 1) else report_mismatch("wb_ack latency", 32'd1, 32'(waited));
        rdata = wb_dat_r;
        @(posedge clk);         // the master sees ack on this edge with the strobe still high
        #1;
        assert (!wb_ack) else stop_with_failure("wb_ack repeated for the same strobe");
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        assert (!wb_ack) else stop_with_failure("wb_ack rose while the strobe was low");
    endtask

    task automatic write_tile(input int i);
        logic [31:0] bits;
        logic [31:0] rd;
        bits = take_bits(8);
        bus_cycle(1'b1, video_pkg::TILE_BASE + 11'(i), bits, rd);
        tile_shadow[i] = bits[7:0];
    endtask

    // lowest tile map index whose entry is not zero
    function automatic int written_tile();
        int found;
        found = 0;
        for (int i = 1023; i >= 0; i--) begin
            if (tile_shadow[i] != 8'd0) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic write_palette(input int i);
        logic [31:0] bits;
        logic [31:0] rd;
        bits = take_bits(12);
        bus_cycle(1'b1, video_pkg::PAL_BASE + 11'(i), bits, rd);
        pal_shadow[i] = bits[11:0];
    endtask

    // frame count must match, line may sit one step either side of the output line
    task automatic check_status(input logic [15:0] frame_exp);
        logic [31:0] rd;
        int          line_gap;
        bus_cycle(1'b0, video_pkg::STATUS_ADDR, 32'd0, rd);
        assert (rd[15:0] == frame_exp)
            else report_mismatch("status frame count", 32'(frame_exp), 32'(rd[15:0]));
        line_gap = (int'(rd[24:16]) - int'(vdump) + V_TOTAL) % V_TOTAL;
        assert (line_gap <= 1 || line_gap == V_TOTAL - 1)
            else report_mismatch("status vdump", 32'(vdump), 32'(rd[24:16]));
    endtask

    task automatic wait_position(input logic [8:0] h, input logic [8:0] v);
        do begin
            @(posedge clk);
            #1;
        end while (!(hdump == h && vdump == v));
    endtask

    // --------------------------------------------------
    // output compare, once per pixel in its last stable cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        logic [8:0] next_h;     // position that has to follow the previous pixel
        logic [8:0] next_v;
        if (rst_n && pxl_cen) begin
            if (out_steps >= 2) begin   // the two pipeline stages hold reset values before
                assert ({lhbl, lvbl, hs, vs} == expected_flags(hdump, vdump))
                    else report_mismatch("lhbl/lvbl/hs/vs", 32'(expected_flags(hdump, vdump)),
                                         32'({lhbl, lvbl, hs, vs}));
                if (!lhbl || !lvbl) begin
                    assert (rgb_word == 12'h000)
                        else report_mismatch("rgb in blanking", 32'd0, 32'(rgb_word));
                end
                if (pix_check) begin
                    assert (rgb_word == expected_rgb(hdump, vdump))
                        else report_mismatch("rgb", 32'(expected_rgb(hdump, vdump)),
                                             32'(rgb_word));
                end
            end
            if (out_steps >= 3) begin
                next_h = (prev_h == H_LAST) ? 9'd0 : prev_h + 9'd1;
                next_v = prev_v;
                if (prev_h == H_LAST) begin     // new line
                    next_v = (prev_v == V_LAST) ? 9'd0 : prev_v + 9'd1;
                end
                assert (hdump == next_h)
                    else report_mismatch("hdump", 32'(next_h), 32'(hdump));
                assert (vdump == next_v)
                    else report_mismatch("vdump", 32'(next_v), 32'(vdump));
            end
            prev_h    = hdump;
            prev_v    = vdump;
            out_steps = out_steps + 1;
        end
    end

    // run limit, three frames plus the bus traffic
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout, the test did not finish within the cycle limit");
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] rd;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        wb_adr   = 11'd0;
        wb_dat_w = 32'd0;
        wb_we    = 1'b0;
        wb_stb   = 1'b0;
        wb_cyc   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!hs) else report_mismatch("hs after reset", 32'd0, 32'(hs));
        assert (!vs) else report_mismatch("vs after reset", 32'd0, 32'(vs));
        assert (!wb_ack) else report_mismatch("wb_ack after reset", 32'd0, 32'(wb_ack));
        assert (rgb_word == 12'h000) else report_mismatch("rgb after reset", 32'd0, 32'(rgb_word));
        check_status(16'd0);
        for (int i = 0; i < 1024; i++) begin
            write_tile(i);
        end
        for (int i = 0; i < 16; i++) begin
            write_palette(i);
        end
        // an entry that holds data still reads back as zero
        bus_cycle(1'b0, video_pkg::TILE_BASE + 11'(written_tile()), 32'd0, rd);
        assert (rd == 32'd0) else report_mismatch("tile map read", 32'd0, rd);
        wait_position(9'd0, 9'd0);      // frame 1 is fetched from the written memories
        check_status(16'd1);
        pix_check = 1'b1;
        wait_position(9'd0, 9'd128);
        check_status(16'd1);
        pix_check = 1'b0;               // rest of this frame mixes old and new palette
        for (int i = 0; i < 16; i++) begin
            write_palette(i);
        end
        wait_position(9'd0, 9'd0);
        check_status(16'd2);
        pix_check = 1'b1;               // all of frame 2 shows the new palette
        wait_position(9'd0, 9'd0);
        check_status(16'd3);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/video_pkg.sv
hdl/video_delay.sv
hdl/video_timer.sv
hdl/tile_fetch.sv
hdl/palette_lookup.sv
hdl/wb_video_regs.sv
hdl/video_top.sv
bench/video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the video testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    -f project.f \
    --top-module video_tb \
    --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vvideo_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "run failed, see $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "run passed"
exit 0
